// ==== bench/bus_cases.txt ====
// op addr sel wdata rdata err, all hex; op bit 0 = write, bit 1 = strobe held from previous
// op f ends the list; rdata is compared on reads that expect no err
// Full-mask write then read back
1 001 f deadbeef 00000000 0
0 001 f 00000000 deadbeef 0
// Partial selects keep the other lanes
1 002 f 11223344 00000000 0
1 002 5 aabbccdd 00000000 0
0 002 f 00000000 11bb33dd 0
1 003 f 01020304 00000000 0
1 003 8 ff000000 00000000 0
1 003 2 0000ee00 00000000 0
0 003 f 00000000 ff02ee04 0
1 0ff f 5a5a5a5a 00000000 0
// Out of range accesses answer with err
1 100 f cafef00d 00000000 1
0 100 f 00000000 00000000 1
1 101 f 0badf00d 00000000 1
1 1ff f 0badf00d 00000000 1
0 fff f 00000000 00000000 1
// Words sharing the low address bits stay untouched
0 001 f 00000000 deadbeef 0
0 0ff f 00000000 5a5a5a5a 0
// Back-to-back requests with the strobe held
1 010 f 10101010 00000000 0
3 011 f 11111111 00000000 0
3 012 f 12121212 00000000 0
3 012 3 0000abcd 00000000 0
3 013 f 13131313 00000000 0
2 010 f 00000000 10101010 0
2 200 f 00000000 00000000 1
2 011 f 00000000 11111111 0
2 012 f 00000000 1212abcd 0
3 800 f 80808080 00000000 1
2 013 f 00000000 13131313 0
// Fresh cycle after the chain
0 001 f 00000000 deadbeef 0
f 000 0 00000000 00000000 0

// ==== src.f ====
rtl/wbc_pkg.sv
rtl/wbc_classic_if.sv
rtl/wbp_to_classic.sv
rtl/wait_timer.sv
rtl/classic_ram.sv
rtl/wb_classic_top.sv
bench/tb_wb_classic_top.sv

// ==== bench/tb_wb_classic_top.sv ====
// Testbench for the Wishbone subsystem top level
// Runs the operations listed in bench/bus_cases.txt, then a random sequence
// that is checked against a byte-merged memory model
module tb_wb_classic_top;
	timeunit 1ns;
	timeprecision 100ps;
	import wbc_pkg::*;

	localparam int    MAX_CASES = 64;
	localparam int    TIMEOUT   = 50;
	localparam int    N_RANDOM  = 60;
	localparam string CASE_FILE = "bench/bus_cases.txt";

	logic     i_clk;
	logic     i_reset;
	logic     i_cyc;
	logic     i_stb;
	logic     i_we;
	wb_addr_t i_addr;
	wb_data_t i_data;
	wb_sel_t  i_sel;
	logic     o_stall;
	logic     o_ack;
	logic     o_err;
	wb_data_t o_data;

	// Six hex words per case in the order op addr sel wdata rdata err
	logic [31:0] case_words [6*MAX_CASES];
	// Memory model and the lanes it has seen written
	wb_data_t model_data [RAM_DEPTH];
	wb_sel_t  model_known [RAM_DEPTH];

	int     value_errors;
	int     other_errors;
	int     requests;
	int     answers;
	integer seed;

	wb_classic_top dut_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_cyc   (i_cyc),
		.i_stb   (i_stb),
		.i_we    (i_we),
		.i_addr  (i_addr),
		.i_data  (i_data),
		.i_sel   (i_sel),
		.o_stall (o_stall),
		.o_ack   (o_ack),
		.o_err   (o_err),
		.o_data  (o_data)
	);

	// 20 ns clock
	always #10 i_clk = ~i_clk;

	// Count every answer on the pipelined port against the requests
	always @(negedge i_clk)
	begin
		if (!i_reset && (o_ack || o_err))
			answers++;
		if (!i_reset && o_ack && o_err)
		begin
			$display("FAILED t=%0t: ack and err high together", $time);
			value_errors++;
		end
	end

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	// Present a request at the current rising edge and return at the edge that takes it
	task automatic send_request(input logic we, input wb_addr_t addr, input wb_sel_t sel,
		input wb_data_t data, output logic got_ack, output logic got_err,
		output wb_data_t got_data);
		int   cycles;
		logic taken;
		cycles   = 0;
		taken    = 1'b0;
		got_ack  = 1'b0;
		got_err  = 1'b0;
		got_data = '0;
		i_cyc  <= 1'b1;
		i_stb  <= 1'b1;
		i_we   <= we;
		i_addr <= addr;
		i_data <= data;
		i_sel  <= sel;
		while (!taken && cycles < TIMEOUT)
		begin
			@(negedge i_clk);
			cycles++;
			if (!o_stall)
			begin
				taken    = 1'b1;
				got_ack  = o_ack;
				got_err  = o_err;
				got_data = o_data;
				// Stall may only drop together with this request's answer
				if (!(o_ack || o_err))
				begin
					$display("FAILED t=%0t: request at %h taken without an answer",
						$time, addr);
					value_errors++;
				end
			end
			else if (o_ack || o_err)
			begin
				$display("FAILED t=%0t: answer for %h while still stalled", $time, addr);
				value_errors++;
			end
		end
		if (!taken)
		begin
			$display("Timeout: request at address %h was never taken", addr);
			other_errors++;
		end
		else
			requests++;
		@(posedge i_clk);
	endtask

	// Drop the strobe and the cycle at the current rising edge
	task automatic release_bus();
		i_cyc <= 1'b0;
		i_stb <= 1'b0;
		@(posedge i_clk);
	endtask

	// Compare one answer; mask limits the read data lanes that are compared
	task automatic check_answer(input logic we, input wb_addr_t addr, input logic exp_err,
		input wb_data_t exp_data, input wb_data_t mask, input logic got_ack,
		input logic got_err, input wb_data_t got_data);
		if (exp_err && (!got_err || got_ack))
		begin
			$display("FAILED t=%0t: %h expected err, got ack=%b err=%b",
				$time, addr, got_ack, got_err);
			value_errors++;
		end
		else if (!exp_err && (!got_ack || got_err))
		begin
			$display("FAILED t=%0t: %h expected ack, got ack=%b err=%b",
				$time, addr, got_ack, got_err);
			value_errors++;
		end
		else if (!exp_err && !we && ((got_data & mask) !== (exp_data & mask)))
		begin
			$display("FAILED t=%0t: read %h gave %h, expected %h (mask %h)",
				$time, addr, got_data, exp_data, mask);
			value_errors++;
		end
	endtask

	// Byte-lane merge of a write into the model
	task automatic merge_write(input wb_addr_t addr, input wb_sel_t sel, input wb_data_t data);
		for (int lane = 0; lane < SEL_W; lane++)
		begin
			if (sel[lane])
			begin
				model_data[addr][8*lane +: 8] = data[8*lane +: 8];
				model_known[addr][lane]       = 1'b1;
			end
		end
	endtask

	// Data mask of the lanes the model knows
	function automatic wb_data_t known_mask(input wb_sel_t known);
		wb_data_t m;
		m = '0;
		for (int lane = 0; lane < SEL_W; lane++)
		begin
			if (known[lane])
				m[8*lane +: 8] = 8'hff;
		end
		return m;
	endfunction

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial
	begin : main_seq
		int          n;
		logic [31:0] op;
		logic [31:0] r;
		logic        we;
		logic        chained;
		logic        bus_busy;
		logic        exp_err;
		wb_addr_t    addr;
		wb_sel_t     sel;
		wb_data_t    data;
		wb_data_t    exp_data;
		wb_data_t    mask;
		logic        got_ack;
		logic        got_err;
		wb_data_t    got_data;

		i_clk        = 1'b0;
		i_reset      = 1'b1;
		i_cyc        = 1'b0;
		i_stb        = 1'b0;
		i_we         = 1'b0;
		i_addr       = '0;
		i_data       = '0;
		i_sel        = '0;
		value_errors = 0;
		other_errors = 0;
		requests     = 0;
		answers      = 0;
		bus_busy     = 1'b0;
		seed         = 36355;
		for (int a = 0; a < RAM_DEPTH; a++)
		begin
			model_data[a]  = '0;
			model_known[a] = '0;
		end
		$readmemh(CASE_FILE, case_words);

		repeat (2) @(posedge i_clk);
		i_reset <= 1'b0;

		// Quiet port after reset
		repeat (3)
		begin
			@(negedge i_clk);
			if (o_ack || o_err || !o_stall)
			begin
				$display("FAILED t=%0t: idle port shows ack=%b err=%b stall=%b",
					$time, o_ack, o_err, o_stall);
				value_errors++;
			end
		end
		@(posedge i_clk);

		// Directed cases
		// Op bit 1 keeps the strobe up from the previous request
		n = 0;
		while (n < MAX_CASES && case_words[6*n] < 32'h4)
		begin
			op       = case_words[6*n];
			we       = op[0];
			chained  = op[1];
			addr     = wb_addr_t'(case_words[6*n+1]);
			sel      = wb_sel_t'(case_words[6*n+2]);
			data     = case_words[6*n+3];
			exp_data = case_words[6*n+4];
			exp_err  = case_words[6*n+5][0];
			if (!chained && bus_busy)
				release_bus();
			send_request(we, addr, sel, data, got_ack, got_err, got_data);
			bus_busy = 1'b1;
			check_answer(we, addr, exp_err, exp_data, '1, got_ack, got_err, got_data);
			if (we && addr < RAM_DEPTH)
				merge_write(addr, sel, data);
			n++;
		end
		if (n == 0)
		begin
			$display("No cases could be read from %s", CASE_FILE);
			other_errors++;
		end

		// Random reads and writes in a small window with the odd out-of-range address
		for (int k = 0; k < N_RANDOM; k++)
		begin
			r       = $random(seed);
			we      = r[0];
			chained = r[1];
			sel     = r[7:4];
			r       = $random(seed);
			if (r[2:0] == 3'd0)
				addr = wb_addr_t'(RAM_DEPTH + int'(r[15:8]));
			else
				addr = wb_addr_t'(32'h40 + r[11:8]);
			data     = $random(seed);
			exp_err  = (addr >= RAM_DEPTH);
			exp_data = '0;
			mask     = '0;
			if (!exp_err)
			begin
				exp_data = model_data[addr];
				mask     = known_mask(model_known[addr]);
			end
			if (!chained && bus_busy)
				release_bus();
			send_request(we, addr, sel, data, got_ack, got_err, got_data);
			bus_busy = 1'b1;
			check_answer(we, addr, exp_err, exp_data, mask, got_ack, got_err, got_data);
			if (we && !exp_err)
				merge_write(addr, sel, data);
		end

		if (bus_busy)
			release_bus();
		@(negedge i_clk);
		if (answers != requests)
		begin
			$display("FAILED t=%0t: %0d answers for %0d requests", $time, answers, requests);
			value_errors++;
		end

		$display("Errors: %0d value, %0d other, %0d requests", value_errors, other_errors,
			requests);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== rtl/wb_classic_top.sv ====
// Top level of the Wishbone subsystem with a pipelined master port
// Bridge, wait-state timer and memory meet on one classic bus
module wb_classic_top (
	input  logic               i_clk,
	input  logic               i_reset,
	// Pipelined Wishbone slave port
	input  logic               i_cyc,
	input  logic               i_stb,
	input  logic               i_we,
	input  wbc_pkg::wb_addr_t  i_addr,
	input  wbc_pkg::wb_data_t  i_data,
	input  wbc_pkg::wb_sel_t   i_sel,
	output logic               o_stall,
	output logic               o_ack,
	output logic               o_err,
	output wbc_pkg::wb_data_t  o_data
);

	////////////////////////////////////////////////////////////
	// Classic bus
	////////////////////////////////////////////////////////////

	wbc_classic_if wb_bus ();

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	// Pipelined to classic conversion
	wbp_to_classic bridge_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_cyc   (i_cyc),
		.i_stb   (i_stb),
		.i_we    (i_we),
		.i_addr  (i_addr),
		.i_data  (i_data),
		.i_sel   (i_sel),
		.o_stall (o_stall),
		.o_ack   (o_ack),
		.o_err   (o_err),
		.o_data  (o_data),
		.bus     (wb_bus)
	);

	// Wait states of each classic cycle
	wait_timer timer_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.bus     (wb_bus)
	);

	// Word memory behind the bridge
	classic_ram ram_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.bus     (wb_bus)
	);

endmodule

// ==== rtl/classic_ram.sv ====
// Classic-cycle Wishbone memory slave with byte-lane writes
// Acknowledges in-range accesses after the wait states, errors at once otherwise
module classic_ram (
	input  logic              i_clk,
	input  logic              i_reset,
	wbc_classic_if.bus_slave  bus
);
	import wbc_pkg::*;

	wb_data_t mem [RAM_DEPTH];
	ram_idx_t idx;
	logic     req;
	logic     in_range;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	// Active classic strobe
	assign req = bus.cyc && bus.stb;

	// Anything at or above the depth is out of range
	assign in_range = (bus.addr < wb_addr_t'(RAM_DEPTH));
	assign idx      = bus.addr[RAM_AW-1:0];

	////////////////////////////////////////////////////////////
	// Answer
	////////////////////////////////////////////////////////////

	// In-range access waits for the timer
	assign bus.ack = req && in_range && bus.wait_done;
	// Bad address answers in the first strobe cycle
	assign bus.err = req && !in_range;

	// Stored word for reads; only sampled on ack
	assign bus.rdata = mem[idx];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Lanes are written in the ack cycle only
	always_ff @(posedge i_clk)
	begin
		if (bus.ack && bus.we)
		begin
			for (int lane = 0; lane < SEL_W; lane++)
			begin
				if (bus.sel[lane])
					mem[idx][8*lane +: 8] <= bus.wdata[8*lane +: 8];
			end
		end
	end

	// Ack only inside a strobe that began RAM_WAIT cycles earlier
	a_ack_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		bus.ack |-> bus.stb && $past(bus.stb, RAM_WAIT));

endmodule

// ==== rtl/wait_timer.sv ====
// Wait-state counter for the classic cycle in progress
// Raises wait_done once the strobe has been up for RAM_WAIT cycles
module wait_timer (
	input  logic          i_clk,
	input  logic          i_reset,
	wbc_classic_if.timer  bus
);
	import wbc_pkg::*;

	wait_cnt_t count;

	// Counts strobe cycles and restarts for every new classic cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			count <= '0;
		// Clear between cycles and once the slave has answered
		else if (!(bus.cyc && bus.stb) || bus.ack || bus.err)
			count <= '0;
		// Hold at the terminal count until the answer
		else if (count != wait_cnt_t'(RAM_WAIT))
			count <= count + 1'b1;
	end

	assign bus.wait_done = (count == wait_cnt_t'(RAM_WAIT));

	// Terminal count is only ever seen during a strobe
	a_done_stb: assert property (@(posedge i_clk) disable iff (i_reset)
		bus.wait_done |-> bus.stb);

endmodule

// ==== rtl/wbp_to_classic.sv ====
// Bridge from a pipelined Wishbone master to a classic-cycle slave
// Holds the master stalled until the slave answers, one request in flight
module wbp_to_classic (
	input  logic               i_clk,
	input  logic               i_reset,
	// Pipelined side
	input  logic               i_cyc,
	input  logic               i_stb,
	input  logic               i_we,
	input  wbc_pkg::wb_addr_t  i_addr,
	input  wbc_pkg::wb_data_t  i_data,
	input  wbc_pkg::wb_sel_t   i_sel,
	output logic               o_stall,
	output logic               o_ack,
	output logic               o_err,
	output wbc_pkg::wb_data_t  o_data,
	// Classic side
	wbc_classic_if.bus_master  bus
);
	import wbc_pkg::*;

	bridge_state_t state;
	logic          answered;

	// Slave answered in this cycle
	assign answered = bus.ack || bus.err;

	////////////////////////////////////////////////////////////
	// Classic request
	////////////////////////////////////////////////////////////

	// Request fields pass straight through
	assign bus.cyc   = i_cyc;
	assign bus.we    = i_we;
	assign bus.addr  = i_addr;
	assign bus.wdata = i_data;
	assign bus.sel   = i_sel;
	// No strobe in RETURNED so each request makes one classic cycle
	assign bus.stb   = i_stb && (state != RETURNED);

	// Request is taken only once its answer is back
	assign o_stall = (state != RETURNED);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
				begin
					// Error from the memory comes in the first strobe cycle
					if (answered)
						state <= RETURNED;
					else if (i_stb)
						state <= WAIT_SLAVE;
				end
				WAIT_SLAVE:
				begin
					if (answered)
						state <= RETURNED;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Answer back to the master one cycle late
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_ack <= 1'b0;
			o_err <= 1'b0;
		end
		else
		begin
			o_ack <= i_cyc && bus.ack;
			o_err <= i_cyc && bus.err;
		end
	end

	// Read data captured with the acknowledge
	always_ff @(posedge i_clk)
	begin
		if (bus.ack)
			o_data <= bus.rdata;
	end

	// Slave never answers ack and err together
	a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_ack && o_err));

	// Slave sees no strobe in RETURNED and so gives no second answer
	a_returned: assert property (@(posedge i_clk) disable iff (i_reset)
		(state == RETURNED) |-> !answered);

endmodule

// ==== rtl/wbc_classic_if.sv ====
// Classic-cycle Wishbone bus between the bridge, the wait-state timer and the memory
// The bridge takes bus_master, the memory bus_slave and the timer its own modport
interface wbc_classic_if;
	import wbc_pkg::*;

	// Request side from the bridge
	logic     cyc;
	logic     stb;
	logic     we;
	wb_addr_t addr;
	wb_data_t wdata;
	wb_sel_t  sel;

	// Answer side from the memory
	wb_data_t rdata;
	logic     ack;
	logic     err;

	// Terminal count reached by the timer
	logic     wait_done;

	modport bus_master (
		output cyc, stb, we, addr, wdata, sel,
		input  rdata, ack, err
	);

	modport bus_slave (
		input  cyc, stb, we, addr, wdata, sel, wait_done,
		output rdata, ack, err
	);

	// Timer only watches the strobe and the answer
	modport timer (
		input  cyc, stb, ack, err,
		output wait_done
	);

endinterface

// ==== rtl/wbc_pkg.sv ====
// Shared widths, types and constants of the Wishbone classic subsystem
// Imported by the bridge, the wait-state timer, the memory and the bus interface
package wbc_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	// Word address width
	localparam int ADDR_W = 12;
	// Data bus width
	localparam int DATA_W = 32;
	// One select bit per byte lane
	localparam int SEL_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0]  wb_sel_t;

	////////////////////////////////////////////////////////////
	// Memory slave
	////////////////////////////////////////////////////////////

	// Words held by the memory; higher addresses answer with err
	localparam int RAM_DEPTH = 256;
	// Index bits needed to reach every word
	localparam int RAM_AW = $clog2(RAM_DEPTH);
	typedef logic [RAM_AW-1:0] ram_idx_t;

	// Wait states before the memory may acknowledge
	localparam int RAM_WAIT = 2;
	// Counter width that can hold the terminal count
	localparam int WAIT_W = $clog2(RAM_WAIT + 1);
	typedef logic [WAIT_W-1:0] wait_cnt_t;

	////////////////////////////////////////////////////////////
	// Bridge FSM
	////////////////////////////////////////////////////////////

	// IDLE        no classic cycle yet for the current request
	// WAIT_SLAVE  classic strobe out, slave has not answered
	// RETURNED    answer registered, request taken this cycle
	typedef enum logic [1:0] {
		IDLE,
		WAIT_SLAVE,
		RETURNED
	} bridge_state_t;

endpackage
